// File: verilog/fftPkg.sv
package fftPkg;

	// address and command widths
	localparam int ADDR_W = 24;
	localparam int PAR_W = 5;
	localparam int MAX_PAR = 16;
	localparam int IDX_W = 16;

	// queue sizing, reads pause two entries short of full
	localparam int FIFO_DEPTH = 16;
	localparam int ADDR_FIFO_LIMIT = 14;

	// twiddles are Q1.14
	localparam int TW_FRAC = 14;

	typedef struct packed {
		logic signed [15:0] re;
		logic signed [15:0] im;
	} cmplxT;

	// read tags, same coding as the response path expects
	typedef enum logic [1:0] {
		TAG_TW = 2'd0,
		TAG_X = 2'd1,
		TAG_Y = 2'd2
	} memTagT;

	typedef struct packed {
		logic write;
		logic [ADDR_W-1:0] addr;
		cmplxT data;
		memTagT tag;
	} memReqT;

	typedef struct packed {
		memTagT tag;
		cmplxT data;
	} memRspT;

	// one butterfly worth of addresses
	typedef struct packed {
		logic [ADDR_W-1:0] evenAddr;
		logic [ADDR_W-1:0] oddAddr;
		logic [ADDR_W-1:0] twidAddr;
		logic last;
	} bflyAddrT;

	typedef struct packed {
		cmplxT even;
		cmplxT odd;
	} resultT;

	typedef enum logic [2:0] {
		IDLE,
		ISSUE_TW,
		ISSUE_Y,
		ISSUE_X,
		ADVANCE
	} seqStateT;

	typedef enum logic [1:0] {
		WR_WAIT,
		WR_EVEN,
		WR_ODD
	} wrStateT;

endpackage

// File: verilog/syncFifo.sv
`timescale 1ns/1ns

module syncFifo #(
	parameter int WIDTH = 32,
	parameter int DEPTH = 16
) (
	input logic CLK,
	input logic RESET,
	input logic push,
	input logic pop,
	input logic [WIDTH-1:0] dataIn,
	output logic [WIDTH-1:0] dataOut,
	output logic empty,
	output logic [$clog2(DEPTH):0] count
);

	logic [WIDTH-1:0] mem [DEPTH];
	logic [$clog2(DEPTH)-1:0] wrPtr;
	logic [$clog2(DEPTH)-1:0] rdPtr;

	// head word is visible without a read strobe
	assign dataOut = mem[rdPtr];
	assign empty = (count == '0);

	always_ff @(posedge CLK or negedge RESET) begin
		if (!RESET) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end else begin
			if (push)
				wrPtr <= wrPtr + 1'b1;
			if (pop)
				rdPtr <= rdPtr + 1'b1;
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge CLK) begin
		if (push)
			mem[wrPtr] <= dataIn;
	end

	// upstream throttling must keep us from ever filling up
	assert property (@(posedge CLK) disable iff (!RESET) push |-> count < DEPTH)
		else $error("syncFifo: push while full");

endmodule

// File: verilog/fftAddrGen.sv
`timescale 1ns/1ns

module fftAddrGen
	import fftPkg::*;
(
	input logic CLK,
	input logic RESET,
	input logic start,
	input logic [PAR_W-1:0] par,
	input logic [ADDR_W-1:0] dataBase,
	input logic [ADDR_W-1:0] twidBase,
	input logic addrTake,
	input logic stageDrained,
	output logic addrValid,
	output bflyAddrT bfly
);

	logic active;
	logic waitDrain;
	logic [PAR_W-1:0] stage;
	logic [PAR_W-1:0] twShift;
	logic [IDX_W-1:0] grp;
	logic [IDX_W-1:0] k;
	logic [IDX_W-1:0] kMax;
	logic [IDX_W-1:0] grpMax;
	logic [ADDR_W-1:0] evenAddr;
	logic lastK;
	logic lastGrp;
	logic lastStage;
	logic take;

	// twiddle stride is N/(2h), i.e. 2^(par-1-stage)
	assign twShift = par - stage - 1'b1;
	assign kMax = (IDX_W'(1) << stage) - 1'b1;
	assign grpMax = (IDX_W'(1) << twShift) - 1'b1;

	assign lastK = (k == kMax);
	assign lastGrp = (grp == grpMax);
	assign lastStage = (stage == par - 1'b1);

	// group g starts at g*2h, odd partner sits h further on
	assign evenAddr = dataBase + (ADDR_W'(grp) << (stage + 1'b1)) + ADDR_W'(k);

	assign bfly.evenAddr = evenAddr;
	assign bfly.oddAddr = evenAddr + (ADDR_W'(1) << stage);
	assign bfly.twidAddr = twidBase + (ADDR_W'(k) << twShift);
	assign bfly.last = lastStage & lastGrp & lastK;

	assign addrValid = active & ~waitDrain;
	assign take = addrValid & addrTake;

	always_ff @(posedge CLK or negedge RESET) begin
		if (!RESET) begin
			active <= 1'b0;
			waitDrain <= 1'b0;
			stage <= '0;
			grp <= '0;
			k <= '0;
		end else if (start) begin
			// zero length means nothing to do at all
			active <= (par != '0);
			waitDrain <= 1'b0;
			stage <= '0;
			grp <= '0;
			k <= '0;
		end else begin
			if (waitDrain && stageDrained)
				waitDrain <= 1'b0;
			if (take) begin
				if (!lastK) begin
					k <= k + 1'b1;
				end else begin
					k <= '0;
					if (!lastGrp) begin
						grp <= grp + 1'b1;
					end else begin
						grp <= '0;
						if (lastStage) begin
							active <= 1'b0;
						end else begin
							// hold off until the old stage is written back
							stage <= stage + 1'b1;
							waitDrain <= 1'b1;
						end
					end
				end
			end
		end
	end

	assert property (@(posedge CLK) disable iff (!RESET) addrValid && !addrTake |=> $stable(bfly))
		else $error("fftAddrGen: butterfly address changed before it was taken");

	assert property (@(posedge CLK) disable iff (!RESET) start |-> par <= MAX_PAR)
		else $error("fftAddrGen: transform size out of range");

endmodule

// File: verilog/fftSequencer.sv
`timescale 1ns/1ns

module fftSequencer
	import fftPkg::*;
(
	input logic CLK,
	input logic RESET,
	input logic start,
	input logic addrValid,
	input bflyAddrT bfly,
	input logic memNext,
	input resultT result,
	input logic resultEmpty,
	output logic addrTake,
	output logic resultPop,
	output logic memAct,
	output memReqT memReq,
	output logic stageDrained,
	output logic done
);

	seqStateT rdState;
	wrStateT wrState;
	logic reqFree;
	logic wrBusy;
	logic rdIssue;
	logic wrIssue;
	logic reqLast;
	logic armed;
	logic lastAccept;
	logic addrEmpty;
	logic addrPop;
	logic [$clog2(FIFO_DEPTH):0] addrCount;
	// {last, odd, even}
	logic [2*ADDR_W:0] wrAddr;

	syncFifo #(
		.WIDTH(2 * ADDR_W + 1),
		.DEPTH(FIFO_DEPTH)
	) addrFifo (
		.CLK(CLK),
		.RESET(RESET),
		.push(addrTake),
		.pop(addrPop),
		.dataIn({bfly.last, bfly.oddAddr, bfly.evenAddr}),
		.dataOut(wrAddr),
		.empty(addrEmpty),
		.count(addrCount)
	);

	// request register can be reloaded
	assign reqFree = ~memAct | memNext;
	assign wrBusy = (wrState != WR_WAIT);
	assign wrIssue = wrBusy & reqFree;
	// reads only get the register when no write wants it
	assign rdIssue = (rdState inside {ISSUE_TW, ISSUE_Y, ISSUE_X}) & reqFree & ~wrBusy;

	assign addrTake = (rdState == ADVANCE);
	assign addrPop = (wrState == WR_ODD) & reqFree;
	assign resultPop = addrPop;

	assign lastAccept = memAct & memNext & memReq.write & reqLast;
	assign stageDrained = addrEmpty & ~(memAct & memReq.write);

	always_ff @(posedge CLK or negedge RESET) begin
		if (!RESET) begin
			rdState <= IDLE;
			wrState <= WR_WAIT;
			memAct <= 1'b0;
			reqLast <= 1'b0;
			armed <= 1'b0;
			done <= 1'b0;
		end else begin
			case (rdState)
				IDLE: begin
					if (addrValid && addrCount < ADDR_FIFO_LIMIT)
						rdState <= ISSUE_TW;
				end
				ISSUE_TW: begin
					if (rdIssue)
						rdState <= ISSUE_Y;
				end
				ISSUE_Y: begin
					if (rdIssue)
						rdState <= ISSUE_X;
				end
				ISSUE_X: begin
					if (rdIssue)
						rdState <= ADVANCE;
				end
				default: rdState <= IDLE;
			endcase

			case (wrState)
				WR_WAIT: begin
					if (!resultEmpty && !addrEmpty)
						wrState <= WR_EVEN;
				end
				WR_EVEN: begin
					if (reqFree)
						wrState <= WR_ODD;
				end
				default: begin
					if (reqFree)
						wrState <= WR_WAIT;
				end
			endcase

			memAct <= wrIssue | rdIssue | (memAct & ~memNext);
			if (wrIssue)
				reqLast <= (wrState == WR_ODD) & wrAddr[2*ADDR_W];
			else if (rdIssue)
				reqLast <= 1'b0;

			// one done per command
			if (start)
				armed <= 1'b1;
			else if (lastAccept)
				armed <= 1'b0;
			done <= lastAccept & armed;
		end
	end

	always_ff @(posedge CLK) begin
		if (wrIssue) begin
			memReq.write <= 1'b1;
			if (wrState == WR_EVEN) begin
				memReq.addr <= wrAddr[ADDR_W-1:0];
				memReq.data <= result.even;
				memReq.tag <= TAG_X;
			end else begin
				memReq.addr <= wrAddr[2*ADDR_W-1:ADDR_W];
				memReq.data <= result.odd;
				memReq.tag <= TAG_Y;
			end
		end else if (rdIssue) begin
			memReq.write <= 1'b0;
			memReq.data <= '0;
			case (rdState)
				ISSUE_TW: begin
					memReq.addr <= bfly.twidAddr;
					memReq.tag <= TAG_TW;
				end
				ISSUE_Y: begin
					memReq.addr <= bfly.oddAddr;
					memReq.tag <= TAG_Y;
				end
				default: begin
					memReq.addr <= bfly.evenAddr;
					memReq.tag <= TAG_X;
				end
			endcase
		end
	end

	assert property (@(posedge CLK) disable iff (!RESET)
		memAct && !memNext |=> memAct && $stable(memReq))
		else $error("fftSequencer: request changed under stall");

	assert property (@(posedge CLK) disable iff (!RESET) addrCount <= FIFO_DEPTH)
		else $error("fftSequencer: address FIFO overrun");

	assert property (@(posedge CLK) disable iff (!RESET) resultPop |-> !resultEmpty && !addrEmpty)
		else $error("fftSequencer: pop from empty FIFO");

endmodule

// File: verilog/fftButterfly.sv
`timescale 1ns/1ns

module fftButterfly
	import fftPkg::*;
(
	input logic CLK,
	input logic RESET,
	input logic opValid,
	input cmplxT twid,
	input cmplxT x,
	input cmplxT y,
	output logic resValid,
	output resultT result
);

	logic v1;
	logic v2;
	logic signed [31:0] yrWr;
	logic signed [31:0] yiWi;
	logic signed [31:0] yrWi;
	logic signed [31:0] yiWr;
	logic signed [32:0] nRe;
	logic signed [32:0] nIm;
	logic signed [33:0] sumRe;
	logic signed [33:0] sumIm;
	logic signed [33:0] difRe;
	logic signed [33:0] difIm;
	cmplxT x1;
	cmplxT x2;

	// scaled by 1/2 per stage so the result stays in range
	assign sumRe = (x2.re + nRe) >>> 1;
	assign sumIm = (x2.im + nIm) >>> 1;
	assign difRe = (x2.re - nRe) >>> 1;
	assign difIm = (x2.im - nIm) >>> 1;

	always_ff @(posedge CLK or negedge RESET) begin
		if (!RESET) begin
			v1 <= 1'b0;
			v2 <= 1'b0;
			resValid <= 1'b0;
		end else begin
			v1 <= opValid;
			v2 <= v1;
			resValid <= v2;
		end
	end

	always_ff @(posedge CLK) begin
		// stage 1, the four partial products
		yrWr <= y.re * twid.re;
		yiWi <= y.im * twid.im;
		yrWi <= y.re * twid.im;
		yiWr <= y.im * twid.re;
		x1 <= x;

		// stage 2, N = W*Y back in data scale
		nRe <= (33'(yrWr) - 33'(yiWi)) >>> TW_FRAC;
		nIm <= (33'(yrWi) + 33'(yiWr)) >>> TW_FRAC;
		x2 <= x1;

		// stage 3
		result.even.re <= sumRe[15:0];
		result.even.im <= sumIm[15:0];
		result.odd.re <= difRe[15:0];
		result.odd.im <= difIm[15:0];
	end

endmodule

// File: verilog/fftTop.sv
`timescale 1ns/1ns

module fftTop
	import fftPkg::*;
(
	input logic CLK,
	input logic RESET,
	input logic act,
	input logic [PAR_W-1:0] par,
	input logic [ADDR_W-1:0] dataBase,
	input logic [ADDR_W-1:0] twidBase,
	input logic memNext,
	input logic memRdy,
	input memRspT memRsp,
	output logic next,
	output logic done,
	output logic memAct,
	output memReqT memReq
);

	logic busy;
	logic accept;
	logic startPulse;
	logic zeroDone;
	logic seqDone;
	logic [PAR_W-1:0] parReg;
	logic [ADDR_W-1:0] dataBaseReg;
	logic [ADDR_W-1:0] twidBaseReg;
	logic addrValid;
	logic addrTake;
	logic stageDrained;
	bflyAddrT bfly;
	logic twEmpty;
	logic yEmpty;
	logic xEmpty;
	logic opValid;
	cmplxT twOp;
	cmplxT yOp;
	cmplxT xOp;
	logic resValid;
	resultT bflyRes;
	resultT resHead;
	logic resEmpty;
	logic resPop;

	assign next = ~busy;
	assign accept = act & next;
	// empty transform finishes on its own
	assign done = seqDone | zeroDone;

	always_ff @(posedge CLK or negedge RESET) begin
		if (!RESET) begin
			busy <= 1'b0;
			startPulse <= 1'b0;
			zeroDone <= 1'b0;
		end else begin
			if (accept)
				busy <= 1'b1;
			else if (done)
				busy <= 1'b0;
			startPulse <= accept;
			zeroDone <= startPulse & (parReg == '0);
		end
	end

	always_ff @(posedge CLK) begin
		if (accept) begin
			parReg <= par;
			dataBaseReg <= dataBase;
			twidBaseReg <= twidBase;
		end
	end

	fftAddrGen addrGen (
		.CLK(CLK),
		.RESET(RESET),
		.start(startPulse),
		.par(parReg),
		.dataBase(dataBaseReg),
		.twidBase(twidBaseReg),
		.addrTake(addrTake),
		.stageDrained(stageDrained),
		.addrValid(addrValid),
		.bfly(bfly)
	);

	fftSequencer seq (
		.CLK(CLK),
		.RESET(RESET),
		.start(startPulse),
		.addrValid(addrValid),
		.bfly(bfly),
		.memNext(memNext),
		.result(resHead),
		.resultEmpty(resEmpty),
		.addrTake(addrTake),
		.resultPop(resPop),
		.memAct(memAct),
		.memReq(memReq),
		.stageDrained(stageDrained),
		.done(seqDone)
	);

	// operands move as a set once all three are in
	assign opValid = ~twEmpty & ~yEmpty & ~xEmpty;

	syncFifo #(.WIDTH($bits(cmplxT)), .DEPTH(FIFO_DEPTH)) twFifo (
		.CLK(CLK),
		.RESET(RESET),
		.push(memRdy && memRsp.tag == TAG_TW),
		.pop(opValid),
		.dataIn(memRsp.data),
		.dataOut(twOp),
		.empty(twEmpty),
		.count()
	);

	syncFifo #(.WIDTH($bits(cmplxT)), .DEPTH(FIFO_DEPTH)) yFifo (
		.CLK(CLK),
		.RESET(RESET),
		.push(memRdy && memRsp.tag == TAG_Y),
		.pop(opValid),
		.dataIn(memRsp.data),
		.dataOut(yOp),
		.empty(yEmpty),
		.count()
	);

	syncFifo #(.WIDTH($bits(cmplxT)), .DEPTH(FIFO_DEPTH)) xFifo (
		.CLK(CLK),
		.RESET(RESET),
		.push(memRdy && memRsp.tag == TAG_X),
		.pop(opValid),
		.dataIn(memRsp.data),
		.dataOut(xOp),
		.empty(xEmpty),
		.count()
	);

	fftButterfly bflyPipe (
		.CLK(CLK),
		.RESET(RESET),
		.opValid(opValid),
		.twid(twOp),
		.x(xOp),
		.y(yOp),
		.resValid(resValid),
		.result(bflyRes)
	);

	// same depth as the address queue, never backs up the pipeline
	syncFifo #(.WIDTH($bits(resultT)), .DEPTH(FIFO_DEPTH)) resFifo (
		.CLK(CLK),
		.RESET(RESET),
		.push(resValid),
		.pop(resPop),
		.dataIn(bflyRes),
		.dataOut(resHead),
		.empty(resEmpty),
		.count()
	);

endmodule

// File: test/fftMemModel.sv
`timescale 1ns/1ns

module fftMemModel
	import fftPkg::*;
(
	input logic CLK,
	input logic RESET,
	input logic memAct,
	input memReqT memReq,
	input int stallPct,
	input int maxLat,
	output logic memNext,
	output logic memRdy,
	output memRspT memRsp
);

	cmplxT mem [4096];
	memRspT rspQ [$];
	int dueQ [$];
	int cycle;
	int lastDue;

	initial begin
		int i;
		memNext = 1'b0;
		memRdy = 1'b0;
		memRsp = '0;
		cycle = 0;
		lastDue = 0;
		// background fill tied to the whole word address
		for (i = 0; i < 4096; i++)
			mem[i] = {4'hd, i[11:0], 4'h3, ~i[11:0]};
	end

	// request taken on the same edge the DUT sees it
	always @(posedge CLK) begin
		int lat;
		int due;
		if (RESET && memAct && memNext) begin
			if (memReq.write) begin
				mem[memReq.addr[11:0]] = memReq.data;
			end else begin
				lat = 1 + int'($urandom % maxLat);
				due = cycle + lat;
				// keep answers in request order
				if (due <= lastDue)
					due = lastDue + 1;
				lastDue = due;
				rspQ.push_back({memReq.tag, mem[memReq.addr[11:0]]});
				dueQ.push_back(due);
			end
		end
	end

	always @(negedge CLK) begin
		int roll;
		cycle = cycle + 1;
		roll = int'($urandom % 100);
		memNext = RESET && (roll >= stallPct);
		memRdy = 1'b0;
		memRsp = '0;
		if (dueQ.size() > 0 && dueQ[0] <= cycle) begin
			memRdy = 1'b1;
			memRsp = rspQ.pop_front();
			void'(dueQ.pop_front());
		end
	end

endmodule

// File: test/fftTb.sv
`timescale 1ns/1ns

module fftTb
	import fftPkg::*;
();

	typedef struct packed {
		logic [PAR_W-1:0] par;
		logic [ADDR_W-1:0] dataBase;
		logic [ADDR_W-1:0] twidBase;
		int stallPct;
		int maxLat;
		logic again;
		int expReq;
	} rowT;

	logic CLK;
	logic RESET;
	logic act;
	logic [PAR_W-1:0] par;
	logic [ADDR_W-1:0] dataBase;
	logic [ADDR_W-1:0] twidBase;
	logic memNext;
	logic memRdy;
	memRspT memRsp;
	logic next;
	logic done;
	logic memAct;
	memReqT memReq;
	int stallPct;
	int maxLat;

	rowT rows [9];
	cmplxT inData [64];
	cmplxT twid [32];
	cmplxT refData [64];
	cmplxT prevOut [64];
	int dataErrors;
	int flowErrors;
	int busErrors;
	int reqCount;
	int actCycles;
	bit holdCheck;
	memReqT heldReq;

	fftTop fftTop_inst (
		.CLK(CLK),
		.RESET(RESET),
		.act(act),
		.par(par),
		.dataBase(dataBase),
		.twidBase(twidBase),
		.memNext(memNext),
		.memRdy(memRdy),
		.memRsp(memRsp),
		.next(next),
		.done(done),
		.memAct(memAct),
		.memReq(memReq)
	);

	fftMemModel memModel (
		.CLK(CLK),
		.RESET(RESET),
		.memAct(memAct),
		.memReq(memReq),
		.stallPct(stallPct),
		.maxLat(maxLat),
		.memNext(memNext),
		.memRdy(memRdy),
		.memRsp(memRsp)
	);

	initial begin
		CLK = 1'b0;
		forever #2 CLK = ~CLK;
	end

	function automatic cmplxT randomData();
		cmplxT v;
		int t;
		t = int'($urandom % 16384) - 8192;
		v.re = t[15:0];
		t = int'($urandom % 16384) - 8192;
		v.im = t[15:0];
		return v;
	endfunction

	// Q1.14, magnitude of each part at most 1.0
	function automatic cmplxT randomTwiddle();
		cmplxT v;
		int t;
		t = int'($urandom % 32769) - 16384;
		v.re = t[15:0];
		t = int'($urandom % 32769) - 16384;
		v.im = t[15:0];
		return v;
	endfunction

	// in-place radix-2 stages over bit-reversed input
	task automatic computeModel(input int lgN);
		int n;
		int h;
		int s;
		int g;
		int k;
		int e;
		int o;
		int nRe;
		int nIm;
		int t;
		cmplxT xv;
		cmplxT yv;
		cmplxT wv;
		n = 1 << lgN;
		for (e = 0; e < n; e++)
			refData[e] = inData[e];
		for (s = 0; s < lgN; s++) begin
			h = 1 << s;
			for (g = 0; g < n / (2 * h); g++) begin
				for (k = 0; k < h; k++) begin
					e = g * 2 * h + k;
					o = e + h;
					xv = refData[e];
					yv = refData[o];
					wv = twid[k << (lgN - 1 - s)];
					nRe = (int'(yv.re) * int'(wv.re) - int'(yv.im) * int'(wv.im)) >>> TW_FRAC;
					nIm = (int'(yv.re) * int'(wv.im) + int'(yv.im) * int'(wv.re)) >>> TW_FRAC;
					t = (int'(xv.re) + nRe) >>> 1;
					refData[e].re = t[15:0];
					t = (int'(xv.im) + nIm) >>> 1;
					refData[e].im = t[15:0];
					t = (int'(xv.re) - nRe) >>> 1;
					refData[o].re = t[15:0];
					t = (int'(xv.im) - nIm) >>> 1;
					refData[o].im = t[15:0];
				end
			end
		end
	endtask

	task automatic checkAddress(input memReqT req);
		logic inDataRange;
		logic inTwidRange;
		int n;
		n = 1 << par;
		inDataRange = (req.addr >= dataBase) && (req.addr < dataBase + n);
		inTwidRange = !req.write && (req.addr >= twidBase) && (req.addr < twidBase + n / 2);
		if (!inDataRange && !inTwidRange) begin
			busErrors++;
			$display("[ERROR] %0t memReq.addr %h lies outside the allowed range for a %s",
				$time, req.addr, req.write ? "write" : "read");
		end
	endtask

	// bus monitor on the edge where a request is taken
	always @(posedge CLK) begin
		if (RESET) begin
			if (memAct)
				actCycles++;
			if (holdCheck && !memAct) begin
				busErrors++;
				$display("[ERROR] %0t memAct expected 1 got 0 under stall", $time);
			end else if (holdCheck && memReq != heldReq) begin
				busErrors++;
				$display("[ERROR] %0t memReq expected %h got %h under stall",
					$time, heldReq, memReq);
			end
			holdCheck = memAct & ~memNext;
			heldReq = memReq;
			if (memAct && memNext) begin
				reqCount++;
				checkAddress(memReq);
			end
		end
	end

	task automatic runRow(input rowT row);
		int n;
		int i;
		logic [ADDR_W-1:0] a;
		cmplxT got;
		n = 1 << row.par;
		stallPct = row.stallPct;
		maxLat = row.maxLat;
		if (!row.again) begin
			for (i = 0; i < n; i++)
				inData[i] = randomData();
			for (i = 0; i < n / 2; i++)
				twid[i] = randomTwiddle();
		end
		for (i = 0; i < n; i++) begin
			a = row.dataBase + i;
			memModel.mem[a[11:0]] = inData[i];
		end
		for (i = 0; i < n / 2; i++) begin
			a = row.twidBase + i;
			memModel.mem[a[11:0]] = twid[i];
		end
		computeModel(row.par);
		reqCount = 0;
		actCycles = 0;

		@(negedge CLK);
		par = row.par;
		dataBase = row.dataBase;
		twidBase = row.twidBase;
		act = 1'b1;
		while (!next)
			@(negedge CLK);
		@(negedge CLK);
		act = 1'b0;
		while (!done) begin
			if (next !== 1'b0) begin
				flowErrors++;
				$display("[ERROR] %0t next expected 0 got %b", $time, next);
			end
			@(negedge CLK);
		end
		if (next !== 1'b0) begin
			flowErrors++;
			$display("[ERROR] %0t next expected 0 got %b", $time, next);
		end
		@(negedge CLK);
		if (next !== 1'b1) begin
			flowErrors++;
			$display("[ERROR] %0t next expected 1 got %b", $time, next);
		end
		// no second done for the same command
		repeat (8) begin
			if (done) begin
				flowErrors++;
				$display("[ERROR] %0t done pulsed again without a command", $time);
			end
			@(negedge CLK);
		end
		if (reqCount != row.expReq) begin
			busErrors++;
			$display("[ERROR] %0t request count expected %0d got %0d", $time, row.expReq, reqCount);
		end
		if (row.par == 0 && actCycles != 0) begin
			busErrors++;
			$display("[ERROR] %0t memAct cycles expected 0 got %0d", $time, actCycles);
		end
		for (i = 0; i < n; i++) begin
			a = row.dataBase + i;
			got = memModel.mem[a[11:0]];
			if (got != refData[i]) begin
				dataErrors++;
				$display("[ERROR] %0t mem[%h] expected %h got %h", $time, a, refData[i], got);
			end
			if (row.again && got != prevOut[i]) begin
				dataErrors++;
				$display("[ERROR] %0t mem[%h] expected %h got %h on the repeated run",
					$time, a, prevOut[i], got);
			end
			prevOut[i] = got;
		end
	endtask

	initial begin
		int r;
		void'($urandom(32'h05ca_ea65));
		RESET = 1'b0;
		act = 1'b0;
		par = '0;
		dataBase = '0;
		twidBase = '0;
		stallPct = 0;
		maxLat = 1;
		// par, dataBase, twidBase, stall %, max latency, reuse previous data, requests
		rows[0] = '{5'd0, 24'h000100, 24'h000800, 0, 1, 1'b0, 0};
		rows[1] = '{5'd1, 24'h000100, 24'h000800, 0, 1, 1'b0, 5};
		rows[2] = '{5'd3, 24'h000200, 24'h000900, 0, 2, 1'b0, 60};
		rows[3] = '{5'd3, 24'h000200, 24'h000900, 40, 6, 1'b1, 60};
		rows[4] = '{5'd5, 24'h000400, 24'h000a00, 0, 3, 1'b0, 400};
		rows[5] = '{5'd5, 24'h000400, 24'h000a00, 50, 9, 1'b1, 400};
		rows[6] = '{5'd6, 24'h000600, 24'h000c00, 25, 4, 1'b0, 960};
		rows[7] = '{5'd6, 24'h000600, 24'h000c00, 60, 12, 1'b1, 960};
		rows[8] = '{5'd0, 24'h000700, 24'h000d00, 50, 5, 1'b0, 0};

		repeat (4) @(negedge CLK);
		RESET = 1'b1;
		@(negedge CLK);
		if (next !== 1'b1 || done !== 1'b0 || memAct !== 1'b0) begin
			flowErrors++;
			$display("[ERROR] %0t next/done/memAct expected 1/0/0 got %b/%b/%b",
				$time, next, done, memAct);
		end

		for (r = 0; r < 9; r++)
			runRow(rows[r]);

		$display("errors: data %0d, handshake %0d, bus %0d", dataErrors, flowErrors, busErrors);
		if (dataErrors + flowErrors + busErrors == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

	// 64 cycles per butterfly per stage, plus slack per row
	initial begin
		int limit;
		int r;
		@(posedge RESET);
		limit = 1000;
		for (r = 0; r < 9; r++)
			limit += 64 * int'(rows[r].par) * ((1 << rows[r].par) / 2) + 100;
		repeat (limit) @(posedge CLK);
		$display("timeout: the run did not finish within %0d cycles", limit);
		$display("FAIL: see errors above");
		$finish;
	end

endmodule

// File: project.f
verilog/fftPkg.sv
verilog/syncFifo.sv
verilog/fftAddrGen.sv
verilog/fftSequencer.sv
verilog/fftButterfly.sv
verilog/fftTop.sv
test/fftMemModel.sv
test/fftTb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the FFT engine testbench with Verilator
set -eo pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f project.f --top-module fftTb -o fftSim

./obj_dir/fftSim | tee sim.log

if grep -q "FAIL: see errors above" sim.log; then
	echo "simulation failed"
	exit 1
fi
if ! grep -q "PASS: all tests" sim.log; then
	echo "simulation ended without a result"
	exit 1
fi
echo "simulation passed"
